// File: verilog/issue_pkg.sv
package issue_pkg;

    // Sizes
    localparam int RS_DEPTH       = 16;
    localparam int DISPATCH_WIDTH = 2;
    localparam int NUM_ALU        = 2;
    localparam int NUM_MULT       = 1;
    localparam int MULT_LATENCY   = 4;
    localparam int TAG_BITS       = 6;
    localparam int BR_BITS        = 4;

    // Unit slots on the done bus, ALUs first, branch last
    localparam int UNIT_ALU0  = 0;
    localparam int UNIT_MULT  = NUM_ALU;
    localparam int UNIT_BR    = NUM_ALU + NUM_MULT;
    localparam int NUM_UNITS  = NUM_ALU + NUM_MULT + 1;

    localparam int CNT_BITS      = $clog2(RS_DEPTH + 1);
    localparam int MULT_CNT_BITS = $clog2(MULT_LATENCY + 1);

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [BR_BITS-1:0]  br_mask_t;

    typedef enum logic [1:0] {
        ALU_OP  = 2'h0,
        MULT_OP = 2'h1,
        BR_OP   = 2'h2
    } fu_type_t;

    typedef enum logic [1:0] {
        NOTHING = 2'h0,
        CLEAR   = 2'h1,
        SQUASH  = 2'h2
    } br_task_t;

    typedef struct packed {
        tag_t tag;
        logic ready;
    } src_tag_t;

    typedef struct packed {
        logic     valid;
        fu_type_t fu_type;
        tag_t     dest;
        src_tag_t src1;
        src_tag_t src2;
        // Unresolved branches this instruction depends on
        br_mask_t b_mask;
        // One-hot id of the branch itself
        br_mask_t br_id;
        logic     mispredict;
    } rs_packet_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } cdb_packet_t;

    typedef struct packed {
        br_task_t br_task;
        br_mask_t br_id;
    } br_result_t;

endpackage

// File: verilog/psel_gen.sv
`timescale 1ns/1ps

module psel_gen #(
    parameter int WIDTH = 16,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]            req,
    output logic [WIDTH-1:0]            gnt,
    output logic [REQS-1:0][WIDTH-1:0]  gnt_bus,
    output logic                        empty
);

    always_comb begin
        logic [WIDTH-1:0] remaining;
        remaining = req;
        gnt = '0;
        gnt_bus = '0;
        for (int r = 0; r < REQS; r++) begin
            // Lowest set bit of what is left
            gnt_bus[r] = remaining & (~remaining + WIDTH'(1));
            remaining = remaining & ~gnt_bus[r];
            gnt = gnt | gnt_bus[r];
        end
    end

    assign empty = ~|req;

endmodule

// File: verilog/reservation_station.sv
`timescale 1ns/1ps

module reservation_station
    import issue_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,

    input  rs_packet_t [DISPATCH_WIDTH-1:0]     dispatch,
    input  cdb_packet_t [DISPATCH_WIDTH-1:0]    cdb,
    input  br_result_t                          br_result,

    input  logic [NUM_ALU-1:0]                  alu_busy,
    input  logic                                mult_busy,
    input  logic                                br_busy,

    output rs_packet_t [NUM_ALU-1:0]            issue_alu,
    output rs_packet_t                          issue_mult,
    output rs_packet_t                          issue_br,

    output logic [CNT_BITS-1:0]                 open_entries
);

    rs_packet_t [RS_DEPTH-1:0] entries;
    rs_packet_t [RS_DEPTH-1:0] next_entries;

    logic [RS_DEPTH-1:0] alu_req;
    logic [RS_DEPTH-1:0] mult_req;
    logic [RS_DEPTH-1:0] br_req;
    logic [RS_DEPTH-1:0] mult_gnt;
    logic [RS_DEPTH-1:0] br_gnt;
    logic [RS_DEPTH-1:0] issued;
    logic [NUM_ALU-1:0][RS_DEPTH-1:0] alu_gnt_bus;
    logic [CNT_BITS-1:0] occupied;

    function automatic rs_packet_t wake(rs_packet_t pkt, cdb_packet_t [DISPATCH_WIDTH-1:0] bus);
        rs_packet_t result;
        result = pkt;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (bus[i].valid && pkt.valid) begin
                if (pkt.src1.tag == bus[i].tag) begin
                    result.src1.ready = 1'b1;
                end
                if (pkt.src2.tag == bus[i].tag) begin
                    result.src2.ready = 1'b1;
                end
            end
        end
        return result;
    endfunction

    function automatic rs_packet_t resolve(rs_packet_t pkt, br_result_t br);
        rs_packet_t result;
        result = pkt;
        if ((pkt.b_mask & br.br_id) != '0) begin
            if (br.br_task == SQUASH) begin
                result = '0;
            end else if (br.br_task == CLEAR) begin
                result.b_mask = pkt.b_mask & ~br.br_id;
            end
        end
        return result;
    endfunction

    psel_gen #(
        .WIDTH (RS_DEPTH),
        .REQS  (NUM_ALU)
    ) alu_psel (
        .req     (alu_req),
        .gnt     (),
        .gnt_bus (alu_gnt_bus),
        .empty   ()
    );

    psel_gen #(
        .WIDTH (RS_DEPTH),
        .REQS  (NUM_MULT)
    ) mult_psel (
        .req     (mult_req),
        .gnt     (mult_gnt),
        .gnt_bus (),
        .empty   ()
    );

    psel_gen #(
        .WIDTH (RS_DEPTH),
        .REQS  (1)
    ) br_psel (
        .req     (br_req),
        .gnt     (br_gnt),
        .gnt_bus (),
        .empty   ()
    );

    // Ready entries request by class, skipping ones being squashed now
    always_comb begin
        logic doomed;
        alu_req = '0;
        mult_req = '0;
        br_req = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            doomed = (br_result.br_task == SQUASH) && ((entries[i].b_mask & br_result.br_id) != '0);
            if (entries[i].valid && entries[i].src1.ready && entries[i].src2.ready && !doomed) begin
                case (entries[i].fu_type)
                    ALU_OP:  alu_req[i] = 1'b1;
                    MULT_OP: mult_req[i] = 1'b1;
                    BR_OP:   br_req[i] = 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // The n-th free ALU takes the n-th grant
    always_comb begin
        int slot;
        slot = 0;
        issue_alu = '0;
        issue_mult = '0;
        issue_br = '0;
        issued = '0;
        for (int k = 0; k < NUM_ALU; k++) begin
            if (!alu_busy[k]) begin
                for (int i = 0; i < RS_DEPTH; i++) begin
                    if (alu_gnt_bus[slot][i]) begin
                        issue_alu[k] = entries[i];
                        issued[i] = 1'b1;
                    end
                end
                slot = slot + 1;
            end
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!mult_busy && mult_gnt[i]) begin
                issue_mult = entries[i];
                issued[i] = 1'b1;
            end
            if (!br_busy && br_gnt[i]) begin
                issue_br = entries[i];
                issued[i] = 1'b1;
            end
        end
    end

    always_comb begin
        rs_packet_t incoming;
        logic placed;
        for (int i = 0; i < RS_DEPTH; i++) begin
            next_entries[i] = resolve(wake(entries[i], cdb), br_result);
            if (issued[i]) begin
                next_entries[i] = '0;
            end
        end
        // New packets see this cycle's broadcast and branch outcome too
        for (int d = 0; d < DISPATCH_WIDTH; d++) begin
            incoming = resolve(wake(dispatch[d], cdb), br_result);
            placed = 1'b0;
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (incoming.valid && !placed && !next_entries[j].valid) begin
                    next_entries[j] = incoming;
                    placed = 1'b1;
                end
            end
        end
    end

    always_comb begin
        occupied = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            occupied = occupied + CNT_BITS'(entries[i].valid);
        end
    end

    assign open_entries = CNT_BITS'(RS_DEPTH) - occupied;

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
        end else begin
            entries <= next_entries;
        end
    end

endmodule

// File: verilog/exec_units.sv
`timescale 1ns/1ps

module exec_units
    import issue_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,

    input  rs_packet_t [NUM_ALU-1:0]        issue_alu,
    input  rs_packet_t                      issue_mult,
    input  rs_packet_t                      issue_br,
    input  logic [NUM_UNITS-1:0]            grant,

    output cdb_packet_t [NUM_UNITS-1:0]     done,
    output logic [NUM_ALU-1:0]              alu_busy,
    output logic                            mult_busy,
    output logic                            br_busy,
    output br_result_t                      br_result
);

    cdb_packet_t [NUM_ALU-1:0] alu_hold;
    cdb_packet_t mult_pend;
    cdb_packet_t mult_hold;
    logic [MULT_CNT_BITS-1:0] mult_count;
    rs_packet_t br_hold;
    logic mult_move;

    // Last countdown step, and the holding register is free or leaving
    assign mult_move = mult_pend.valid && (mult_count == MULT_CNT_BITS'(1))
        && (!mult_hold.valid || grant[UNIT_MULT]);

    always_comb begin
        for (int k = 0; k < NUM_ALU; k++) begin
            alu_busy[k] = alu_hold[k].valid & ~grant[UNIT_ALU0+k];
            done[UNIT_ALU0+k] = alu_hold[k];
        end
        mult_busy = mult_pend.valid | (mult_hold.valid & ~grant[UNIT_MULT]);
        br_busy = br_hold.valid & ~grant[UNIT_BR];
        done[UNIT_MULT] = mult_hold;
        done[UNIT_BR].valid = br_hold.valid;
        done[UNIT_BR].tag = br_hold.dest;
    end

    // Branch outcome goes out with its CDB grant
    always_comb begin
        br_result.br_task = NOTHING;
        br_result.br_id = '0;
        if (br_hold.valid && grant[UNIT_BR]) begin
            br_result.br_task = br_hold.mispredict ? SQUASH : CLEAR;
            br_result.br_id = br_hold.br_id;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < NUM_ALU; k++) begin
                alu_hold[k].valid <= 1'b0;
            end
            mult_pend.valid <= 1'b0;
            mult_hold.valid <= 1'b0;
            mult_count <= '0;
            br_hold.valid <= 1'b0;
        end else begin
            for (int k = 0; k < NUM_ALU; k++) begin
                if (issue_alu[k].valid) begin
                    alu_hold[k].valid <= 1'b1;
                    alu_hold[k].tag <= issue_alu[k].dest;
                end else if (grant[UNIT_ALU0+k]) begin
                    alu_hold[k].valid <= 1'b0;
                end
            end

            if (issue_mult.valid) begin
                mult_pend.valid <= 1'b1;
                mult_pend.tag <= issue_mult.dest;
                mult_count <= MULT_CNT_BITS'(MULT_LATENCY);
            end else if (mult_move) begin
                mult_pend.valid <= 1'b0;
            end else if (mult_pend.valid && mult_count > MULT_CNT_BITS'(1)) begin
                mult_count <= mult_count - MULT_CNT_BITS'(1);
            end

            if (mult_move) begin
                mult_hold <= mult_pend;
            end else if (grant[UNIT_MULT]) begin
                mult_hold.valid <= 1'b0;
            end

            if (issue_br.valid) begin
                br_hold <= issue_br;
            end else if (grant[UNIT_BR]) begin
                br_hold.valid <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter
    import issue_pkg::*;
(
    input  cdb_packet_t [NUM_UNITS-1:0]         done,
    output logic [NUM_UNITS-1:0]                grant,
    output cdb_packet_t [DISPATCH_WIDTH-1:0]    cdb
);

    logic [NUM_UNITS-1:0] req;
    logic [NUM_UNITS-1:0] gnt;
    logic [DISPATCH_WIDTH-1:0][NUM_UNITS-1:0] gnt_bus;

    // Unit behind each priority position: branch, multiplier, then ALUs by index
    function automatic int unit_at(int pos);
        if (pos == 0) begin
            return UNIT_BR;
        end
        if (pos == 1) begin
            return UNIT_MULT;
        end
        return UNIT_ALU0 + pos - 2;
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_UNITS; i++) begin
            req[i] = done[unit_at(i)].valid;
        end
    end

    psel_gen #(
        .WIDTH (NUM_UNITS),
        .REQS  (DISPATCH_WIDTH)
    ) cdb_psel (
        .req     (req),
        .gnt     (gnt),
        .gnt_bus (gnt_bus),
        .empty   ()
    );

    always_comb begin
        grant = '0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            grant[unit_at(i)] = gnt[i];
        end
        // One grant vector per CDB slot
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            cdb[s] = '0;
            for (int i = 0; i < NUM_UNITS; i++) begin
                if (gnt_bus[s][i]) begin
                    cdb[s] = done[unit_at(i)];
                end
            end
        end
    end

endmodule

// File: verilog/issue_core.sv
`timescale 1ns/1ps

module issue_core
    import issue_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  rs_packet_t [DISPATCH_WIDTH-1:0]     dispatch,
    output cdb_packet_t [DISPATCH_WIDTH-1:0]    cdb,
    output br_result_t                          br_result,
    output logic [CNT_BITS-1:0]                 open_entries
);

    rs_packet_t [NUM_ALU-1:0] issue_alu;
    rs_packet_t issue_mult;
    rs_packet_t issue_br;
    logic [NUM_ALU-1:0] alu_busy;
    logic mult_busy;
    logic br_busy;
    cdb_packet_t [NUM_UNITS-1:0] done;
    logic [NUM_UNITS-1:0] grant;

    reservation_station i_reservation_station (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .cdb          (cdb),
        .br_result    (br_result),
        .alu_busy     (alu_busy),
        .mult_busy    (mult_busy),
        .br_busy      (br_busy),
        .issue_alu    (issue_alu),
        .issue_mult   (issue_mult),
        .issue_br     (issue_br),
        .open_entries (open_entries)
    );

    exec_units i_exec_units (
        .clock      (clock),
        .reset      (reset),
        .issue_alu  (issue_alu),
        .issue_mult (issue_mult),
        .issue_br   (issue_br),
        .grant      (grant),
        .done       (done),
        .alu_busy   (alu_busy),
        .mult_busy  (mult_busy),
        .br_busy    (br_busy),
        .br_result  (br_result)
    );

    cdb_arbiter i_cdb_arbiter (
        .done  (done),
        .grant (grant),
        .cdb   (cdb)
    );

endmodule

// File: sim/issue_core_tb.sv
`timescale 1ns/1ps

module issue_core_tb
    import issue_pkg::*;
();

    localparam int MAX_RECS = 64;

    logic clock;
    logic reset;
    rs_packet_t [DISPATCH_WIDTH-1:0] dispatch;
    cdb_packet_t [DISPATCH_WIDTH-1:0] cdb;
    br_result_t br_result;
    logic [CNT_BITS-1:0] open_entries;

    int rec_test [MAX_RECS];
    int rec_wait [MAX_RECS];
    int rec_last [MAX_RECS];
    rs_packet_t rec_p0 [MAX_RECS];
    rs_packet_t rec_p1 [MAX_RECS];
    int nrec = 0;

    // Scoreboard, indexed by tag
    bit expect_done [64];
    bit seen [64];
    int seen_cycle [64];
    bit wait1 [64];
    bit wait2 [64];
    tag_t src1 [64];
    tag_t src2 [64];
    br_result_t exp_br [$];
    br_mask_t bad_ids;
    int outstanding;
    int squash_count;
    int min_open;
    int open_before;
    bit squash_seen;
    bit monitor_on = 0;
    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;

    issue_core i_issue_core (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .cdb          (cdb),
        .br_result    (br_result),
        .open_entries (open_entries)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic check_value(input int actual, input int expected, input string msg);
        checks++;
        if (actual != expected) begin
            $display("FAILED at %0t: %s (got %0d, expected %0d)", $time, msg, actual, expected);
            errors++;
        end
    endtask

    task automatic read_vectors();
        int fd;
        int n;
        string line;
        int f [23];
        fd = $fopen("sim/issue_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file sim/issue_vectors.txt");
            errors++;
            return;
        end
        // Two comment lines describe the columns
        n = $fgets(line, fd);
        n = $fgets(line, fd);
        while (!$feof(fd) && nrec < MAX_RECS) begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22]);
            if (n == 23) begin
                rec_test[nrec] = f[0];
                rec_wait[nrec] = f[1];
                rec_last[nrec] = f[2];
                rec_p0[nrec] = {f[3][0], f[4][1:0], f[5][5:0], f[6][5:0], f[7][0], f[8][5:0],
                    f[9][0], f[10][3:0], f[11][3:0], f[12][0]};
                rec_p1[nrec] = {f[13][0], f[14][1:0], f[15][5:0], f[16][5:0], f[17][0],
                    f[18][5:0], f[19][0], f[20][3:0], f[21][3:0], f[22][0]};
                nrec++;
            end
        end
        $fclose(fd);
    endtask

    // Expected outcome of one dispatched packet
    task automatic note_dispatch(input rs_packet_t p);
        if (p.valid) begin
            if (p.fu_type == BR_OP) begin
                exp_br.push_back({p.mispredict ? SQUASH : CLEAR, p.br_id});
                if (p.mispredict) begin
                    bad_ids = bad_ids | p.br_id;
                end
            end
            if ((p.b_mask & bad_ids) != '0) begin
                expect_done[p.dest] = 1'b0;
                squash_count++;
            end else begin
                expect_done[p.dest] = 1'b1;
                outstanding++;
            end
            wait1[p.dest] = !p.src1.ready;
            wait2[p.dest] = !p.src2.ready;
            src1[p.dest] = p.src1.tag;
            src2[p.dest] = p.src2.tag;
        end
    endtask

    always @(negedge clock) begin
        tag_t t;
        br_result_t eb;
        cycle++;
        if (monitor_on) begin
            if (squash_seen) begin
                check_value(int'(open_entries) - open_before, squash_count,
                    "open entries rise after squash");
                squash_seen = 1'b0;
            end
            if (int'(open_entries) < min_open) begin
                min_open = int'(open_entries);
            end
            for (int s = 0; s < DISPATCH_WIDTH; s++) begin
                if (cdb[s].valid) begin
                    t = cdb[s].tag;
                    check_value(int'(expect_done[t]), 1, $sformatf("tag %0d expected on CDB", t));
                    check_value(int'(seen[t]), 0, $sformatf("tag %0d seen only once", t));
                    if (wait1[t]) begin
                        check_value(int'(seen[src1[t]] && seen_cycle[src1[t]] < cycle), 1,
                            $sformatf("tag %0d after its first producer", t));
                    end
                    if (wait2[t]) begin
                        check_value(int'(seen[src2[t]] && seen_cycle[src2[t]] < cycle), 1,
                            $sformatf("tag %0d after its second producer", t));
                    end
                    if (expect_done[t] && !seen[t]) begin
                        outstanding--;
                    end
                    seen[t] = 1'b1;
                    seen_cycle[t] = cycle;
                end
            end
            if (br_result.br_task != NOTHING) begin
                if (exp_br.size() == 0) begin
                    $display("A branch result arrived with no branch outstanding at %0t", $time);
                    errors++;
                end else begin
                    eb = exp_br.pop_front();
                    check_value(int'(br_result.br_task), int'(eb.br_task), "branch task");
                    check_value(int'(br_result.br_id), int'(eb.br_id), "branch id");
                end
                if (br_result.br_task == SQUASH) begin
                    open_before = int'(open_entries);
                    squash_seen = 1'b1;
                end
            end
        end
    end

    initial begin
        read_vectors();
        wait (nrec > 0);
        #(nrec * 40 * 20);
        $display("Timeout: the run did not finish within %0d cycles", nrec * 40);
        $display("Errors found");
        $finish;
    end

    initial begin
        int idx;
        int cur;
        reset = 1'b1;
        dispatch = '0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value(int'(open_entries), RS_DEPTH, "open entries after reset");
        check_value(int'(cdb[0].valid | cdb[1].valid), 0, "CDB idle after reset");
        check_value(int'(br_result.br_task), int'(NOTHING), "branch task after reset");
        tests++;
        $display("Test 1 finished, %0d errors so far", errors);
        monitor_on = 1'b1;
        idx = 0;
        while (idx < nrec) begin
            cur = rec_test[idx];
            for (int i = 0; i < 64; i++) begin
                expect_done[i] = 1'b0;
                seen[i] = 1'b0;
                wait1[i] = 1'b0;
                wait2[i] = 1'b0;
            end
            exp_br.delete();
            bad_ids = '0;
            outstanding = 0;
            squash_count = 0;
            min_open = RS_DEPTH;
            do begin
                repeat (rec_wait[idx]) begin
                    @(posedge clock);
                    dispatch <= '0;
                end
                @(posedge clock);
                dispatch[0] <= rec_p0[idx];
                dispatch[1] <= rec_p1[idx];
                note_dispatch(rec_p0[idx]);
                note_dispatch(rec_p1[idx]);
                idx++;
            end while (rec_last[idx-1] == 0 && idx < nrec);
            @(posedge clock);
            dispatch <= '0;
            do @(negedge clock); while (!(outstanding == 0 && open_entries == RS_DEPTH));
            // Quiet period so a squashed tag would still show up
            repeat (8) @(negedge clock);
            check_value(int'(open_entries), RS_DEPTH, "open entries after test");
            check_value(exp_br.size(), 0, "all branches resolved");
            if (cur == 4) begin
                check_value(min_open, 0, "station filled");
            end
            tests++;
            $display("Test %0d finished, %0d errors so far", cur, errors);
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: sim/issue_vectors.txt
# test wait last | valid fu dest src1 rdy1 src2 rdy2 mask br_id mispredict (packet 0, packet 1)
# all hex; fu 0 ALU, 1 MULT, 2 BR; tag 00 with ready 1 is an operand that is always ready
2 0 0 1 0 01 00 1 00 1 0 0 0 1 0 02 00 1 00 1 0 0 0
2 0 0 1 0 03 00 1 00 1 0 0 0 1 0 04 00 1 00 1 0 0 0
2 0 1 1 0 05 00 1 00 1 0 0 0 1 0 06 00 1 00 1 0 0 0
3 0 0 1 0 20 00 1 00 1 0 0 0 1 1 21 20 0 00 1 0 0 0
3 0 1 1 0 22 21 0 20 0 0 0 0 1 0 23 22 0 00 1 0 0 0
4 0 0 1 1 3a 00 1 00 1 0 0 0 1 1 3b 3a 0 00 1 0 0 0
4 0 0 1 1 3c 3b 0 00 1 0 0 0 1 0 10 3c 0 00 1 0 0 0
4 0 0 1 0 11 3c 0 00 1 0 0 0 1 0 12 3c 0 00 1 0 0 0
4 0 0 1 0 13 3c 0 00 1 0 0 0 1 0 14 3c 0 00 1 0 0 0
4 0 0 1 0 15 3c 0 00 1 0 0 0 1 0 16 3c 0 00 1 0 0 0
4 0 0 1 0 17 3c 0 00 1 0 0 0 1 0 18 3c 0 00 1 0 0 0
4 0 0 1 0 19 3c 0 00 1 0 0 0 1 0 1a 3c 0 00 1 0 0 0
4 0 0 1 0 1b 3c 0 00 1 0 0 0 1 0 1c 3c 0 00 1 0 0 0
4 0 1 1 0 1d 3c 0 00 1 0 0 0 1 0 1e 3c 0 00 1 0 0 0
5 0 0 1 2 28 00 1 00 1 0 2 0 1 0 29 00 1 00 1 2 0 0
5 0 1 1 1 2a 29 0 00 1 2 0 0 0 0 00 00 0 00 0 0 0 0
6 0 0 1 2 30 00 1 00 1 0 1 1 1 0 31 3f 0 00 1 1 0 0
6 0 1 1 0 32 3f 0 00 1 1 0 0 1 0 33 3f 0 00 1 1 0 0

// File: vlog.f
verilog/issue_pkg.sv
verilog/psel_gen.sv
verilog/reservation_station.sv
verilog/exec_units.sv
verilog/cdb_arbiter.sv
verilog/issue_core.sv
sim/issue_core_tb.sv

// File: run_sim.sh
#!/bin/bash
# Compile with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module issue_core_tb -f vlog.f -o issue_sim > build.log 2>&1 \
    && ./obj_dir/issue_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -qx "No errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
